// File: rv_decode_pkg.sv
package rv_decode_pkg;

	localparam int XLEN       = 64;
	localparam int ILEN       = 32;
	localparam int REG_ADDR_W = 5;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011,
		OP_IMM    = 7'b0010011,
		OP_AUIPC  = 7'b0010111,
		OP_IMM_32 = 7'b0011011,
		OP_STORE  = 7'b0100011,
		OP        = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_32     = 7'b0111011,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	// word ops reuse these codes together with is_word
	typedef enum logic [4:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
		ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
		ALU_JUMP, ALU_IMMVAL
	} alu_op_e;

	typedef enum logic [2:0] {
		T_NONE, T_R, T_I, T_S, T_SB, T_U, T_UJ
	} instr_type_e;

	typedef enum logic [1:0] {
		MEM_NONE, MEM_READ, MEM_WRITE
	} mem_access_e;

	typedef enum logic [2:0] {
		SZ_NONE, SZ_BYTE, SZ_HALF, SZ_WORD, SZ_DOUBLE,
		SZ_UBYTE, SZ_UHALF, SZ_UWORD
	} mem_size_e;

	typedef enum logic [1:0] {
		BR_NONE, BR_COND, BR_UNCOND
	} branch_e;

	// the _PC selects get the instruction address added
	typedef enum logic [2:0] {
		IMM_ZERO, IMM_I, IMM_SHAMT, IMM_S, IMM_SB_PC, IMM_U, IMM_U_PC, IMM_UJ_PC
	} imm_sel_e;

endpackage

// File: decode_if.sv
`timescale 1ns/1ps

interface decode_if
	import rv_decode_pkg::*;
#(
	parameter int XLEN_P = XLEN
);
	logic [REG_ADDR_W-1:0] rd;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [XLEN_P-1:0]     imm;
	alu_op_e               alu_op;
	instr_type_e           instr_type;
	mem_access_e           mem_access;
	mem_size_e             mem_size;
	branch_e               branch;
	logic                  reg_write;
	logic                  is_ecall;
	logic                  is_word;
	logic                  illegal;

	modport producer (
		output rd, rs1, rs2, alu_op, instr_type, mem_access, mem_size, branch,
		output reg_write, is_ecall, is_word, illegal
	);

	modport imm_producer (output imm);

	modport consumer (
		input rd, rs1, rs2, imm, alu_op, instr_type, mem_access, mem_size, branch,
		input reg_write, is_ecall, is_word, illegal
	);
endinterface

// File: ctrl_decode.sv
`timescale 1ns/1ps

module ctrl_decode
	import rv_decode_pkg::*;
#(
	parameter int ILEN_P = ILEN
) (
	input  logic [ILEN_P-1:0] i_instr,
	output imm_sel_e          o_imm_sel,
	decode_if.producer        dec
);

	opcode_e    opcode;
	logic [2:0] func3;
	logic [6:0] func7;
	logic       bad;

	assign opcode = opcode_e'(i_instr[6:0]);
	assign func3  = i_instr[14:12];
	assign func7  = i_instr[31:25];

	always_comb begin
		dec.rd         = i_instr[11:7];
		dec.rs1        = i_instr[19:15];
		dec.rs2        = i_instr[24:20];
		dec.alu_op     = ALU_NONE;
		dec.instr_type = T_NONE;
		dec.mem_access = MEM_NONE;
		dec.mem_size   = SZ_NONE;
		dec.branch     = BR_NONE;
		dec.reg_write  = 1'b0;
		dec.is_ecall   = 1'b0;
		dec.is_word    = 1'b0;
		o_imm_sel      = IMM_ZERO;
		bad            = 1'b0;

		case (opcode)
			OP_LUI, OP_AUIPC: begin
				dec.alu_op     = ALU_IMMVAL;
				dec.instr_type = T_U;
				dec.reg_write  = 1'b1;
				o_imm_sel      = (opcode == OP_AUIPC) ? IMM_U_PC : IMM_U;
			end
			OP_JAL: begin
				dec.alu_op     = ALU_JUMP;
				dec.instr_type = T_UJ;
				dec.reg_write  = 1'b1;
				dec.branch     = BR_UNCOND;
				o_imm_sel      = IMM_UJ_PC;
			end
			OP_JALR: begin
				// target is rs1 + I immediate
				bad            = (func3 != 3'b000);
				dec.alu_op     = ALU_ADD;
				dec.instr_type = T_I;
				dec.reg_write  = 1'b1;
				dec.branch     = BR_UNCOND;
				o_imm_sel      = IMM_I;
			end
			OP_BRANCH: begin
				case (func3)
					3'b000: dec.alu_op = ALU_EQ;
					3'b001: dec.alu_op = ALU_NE;
					3'b100: dec.alu_op = ALU_LT;
					3'b101: dec.alu_op = ALU_GE;
					3'b110: dec.alu_op = ALU_LTU;
					3'b111: dec.alu_op = ALU_GEU;
					default: bad = 1'b1;
				endcase
				dec.instr_type = T_SB;
				dec.branch     = BR_COND;
				o_imm_sel      = IMM_SB_PC;
			end
			OP_LOAD: begin
				case (func3)
					3'b000: dec.mem_size = SZ_BYTE;
					3'b001: dec.mem_size = SZ_HALF;
					3'b010: dec.mem_size = SZ_WORD;
					3'b011: dec.mem_size = SZ_DOUBLE;
					3'b100: dec.mem_size = SZ_UBYTE;
					3'b101: dec.mem_size = SZ_UHALF;
					3'b110: dec.mem_size = SZ_UWORD;
					default: bad = 1'b1;
				endcase
				dec.alu_op     = ALU_ADD;
				dec.instr_type = T_I;
				dec.reg_write  = 1'b1;
				dec.mem_access = MEM_READ;
				o_imm_sel      = IMM_I;
			end
			OP_STORE: begin
				case (func3)
					3'b000: dec.mem_size = SZ_BYTE;
					3'b001: dec.mem_size = SZ_HALF;
					3'b010: dec.mem_size = SZ_WORD;
					3'b011: dec.mem_size = SZ_DOUBLE;
					default: bad = 1'b1;
				endcase
				dec.alu_op     = ALU_ADD;
				dec.instr_type = T_S;
				dec.mem_access = MEM_WRITE;
				o_imm_sel      = IMM_S;
			end
			OP_IMM: begin
				o_imm_sel = IMM_I;
				case (func3)
					3'b000: dec.alu_op = ALU_ADD;
					3'b010: dec.alu_op = ALU_SLT;
					3'b011: dec.alu_op = ALU_SLTU;
					3'b100: dec.alu_op = ALU_XOR;
					3'b110: dec.alu_op = ALU_OR;
					3'b111: dec.alu_op = ALU_AND;
					3'b001: begin
						// func7[0] is shamt[5] on RV64
						o_imm_sel  = IMM_SHAMT;
						dec.alu_op = ALU_SLL;
						bad        = (func7[6:1] != 6'b000000);
					end
					default: begin
						o_imm_sel = IMM_SHAMT;
						if (func7[6:1] == 6'b000000)
							dec.alu_op = ALU_SRL;
						else if (func7[6:1] == 6'b010000)
							dec.alu_op = ALU_SRA;
						else
							bad = 1'b1;
					end
				endcase
				dec.instr_type = T_I;
				dec.reg_write  = 1'b1;
			end
			OP_IMM_32: begin
				casez ({func7, func3})
					{7'b???????, 3'b000}: begin
						dec.alu_op = ALU_ADD;
						o_imm_sel  = IMM_I;
					end
					{7'b0000000, 3'b001}: begin
						dec.alu_op = ALU_SLL;
						o_imm_sel  = IMM_SHAMT;
					end
					{7'b0000000, 3'b101}: begin
						dec.alu_op = ALU_SRL;
						o_imm_sel  = IMM_SHAMT;
					end
					{7'b0100000, 3'b101}: begin
						dec.alu_op = ALU_SRA;
						o_imm_sel  = IMM_SHAMT;
					end
					default: bad = 1'b1;
				endcase
				dec.instr_type = T_I;
				dec.reg_write  = 1'b1;
				dec.is_word    = 1'b1;
			end
			OP, OP_32: begin
				case ({func7, func3})
					{7'b0000000, 3'b000}: dec.alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: dec.alu_op = ALU_SUB;
					{7'b0000000, 3'b001}: dec.alu_op = ALU_SLL;
					{7'b0000000, 3'b010}: dec.alu_op = ALU_SLT;
					{7'b0000000, 3'b011}: dec.alu_op = ALU_SLTU;
					{7'b0000000, 3'b100}: dec.alu_op = ALU_XOR;
					{7'b0000000, 3'b101}: dec.alu_op = ALU_SRL;
					{7'b0100000, 3'b101}: dec.alu_op = ALU_SRA;
					{7'b0000000, 3'b110}: dec.alu_op = ALU_OR;
					{7'b0000000, 3'b111}: dec.alu_op = ALU_AND;
					{7'b0000001, 3'b000}: dec.alu_op = ALU_MUL;
					{7'b0000001, 3'b001}: dec.alu_op = ALU_MULH;
					{7'b0000001, 3'b010}: dec.alu_op = ALU_MULHSU;
					{7'b0000001, 3'b011}: dec.alu_op = ALU_MULHU;
					{7'b0000001, 3'b100}: dec.alu_op = ALU_DIV;
					{7'b0000001, 3'b101}: dec.alu_op = ALU_DIVU;
					{7'b0000001, 3'b110}: dec.alu_op = ALU_REM;
					{7'b0000001, 3'b111}: dec.alu_op = ALU_REMU;
					default: bad = 1'b1;
				endcase
				// the W group has no slt, logic ops or high multiplies
				if (opcode == OP_32 && (func3 == 3'b010 || func3 == 3'b011 ||
						(func3 == 3'b001 && func7 == 7'b0000001) ||
						(func3 == 3'b100 && func7 == 7'b0000000) ||
						(func3[2:1] == 2'b11 && func7 == 7'b0000000)))
					bad = 1'b1;
				dec.instr_type = T_R;
				dec.reg_write  = 1'b1;
				dec.is_word    = (opcode == OP_32);
			end
			OP_SYSTEM: begin
				// only the exact ecall encoding is supported
				if (i_instr == ILEN_P'(32'h0000_0073)) begin
					dec.rd       = '0;
					dec.rs1      = '0;
					dec.rs2      = '0;
					dec.is_ecall = 1'b1;
				end else begin
					bad = 1'b1;
				end
			end
			default: bad = 1'b1;
		endcase

		// illegal words keep only the raw register fields
		if (bad) begin
			dec.alu_op     = ALU_NONE;
			dec.instr_type = T_NONE;
			dec.mem_access = MEM_NONE;
			dec.mem_size   = SZ_NONE;
			dec.branch     = BR_NONE;
			dec.reg_write  = 1'b0;
			dec.is_word    = 1'b0;
			o_imm_sel      = IMM_ZERO;
		end
		dec.illegal = bad;
	end

endmodule

// File: imm_gen.sv
`timescale 1ns/1ps

module imm_gen
	import rv_decode_pkg::*;
#(
	parameter int XLEN_P = XLEN,
	parameter int ILEN_P = ILEN
) (
	input  logic [ILEN_P-1:0] i_instr,
	input  logic [XLEN_P-1:0] i_pc,
	input  imm_sel_e          i_imm_sel,
	decode_if.imm_producer    dec
);

	// sign bit of every immediate format
	localparam int SIGN = ILEN_P - 1;

	logic [XLEN_P-1:0] imm_i;
	logic [XLEN_P-1:0] imm_s;
	logic [XLEN_P-1:0] imm_sb;
	logic [XLEN_P-1:0] imm_u;
	logic [XLEN_P-1:0] imm_uj;
	logic [XLEN_P-1:0] shamt;

	assign imm_i  = {{(XLEN_P-12){i_instr[SIGN]}}, i_instr[31:20]};
	assign imm_s  = {{(XLEN_P-12){i_instr[SIGN]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_sb = {{(XLEN_P-12){i_instr[SIGN]}}, i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u  = {{(XLEN_P-32){i_instr[SIGN]}}, i_instr[31:12], 12'b0};
	assign imm_uj = {{(XLEN_P-20){i_instr[SIGN]}}, i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	// 6-bit shift amount, W shifts have bit 25 clear
	assign shamt  = {{(XLEN_P-6){1'b0}}, i_instr[25:20]};

	always_comb begin
		case (i_imm_sel)
			IMM_I:     dec.imm = imm_i;
			IMM_SHAMT: dec.imm = shamt;
			IMM_S:     dec.imm = imm_s;
			IMM_SB_PC: dec.imm = imm_sb + i_pc;
			IMM_U:     dec.imm = imm_u;
			IMM_U_PC:  dec.imm = imm_u + i_pc;
			IMM_UJ_PC: dec.imm = imm_uj + i_pc;
			default:   dec.imm = '0;
		endcase
	end

endmodule

// File: wb_decode_slave.sv
`timescale 1ns/1ps

module wb_decode_slave
	import rv_decode_pkg::*;
#(
	parameter int XLEN_P = XLEN
) (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	decode_if.consumer            dec,
	output logic                  o_wb_ack,
	output logic [REG_ADDR_W-1:0] o_rd,
	output logic [REG_ADDR_W-1:0] o_rs1,
	output logic [REG_ADDR_W-1:0] o_rs2,
	output logic [XLEN_P-1:0]     o_imm,
	output alu_op_e               o_alu_op,
	output instr_type_e           o_instr_type,
	output logic                  o_reg_write,
	output mem_access_e           o_mem_access,
	output mem_size_e             o_mem_size,
	output branch_e               o_branch,
	output logic                  o_is_ecall,
	output logic                  o_is_word,
	output logic                  o_illegal
);

	logic req;

	// new request only while ack is low, so a held stb is served every other cycle
	assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_wb_ack     <= 1'b0;
			o_rd         <= '0;
			o_rs1        <= '0;
			o_rs2        <= '0;
			o_imm        <= '0;
			o_alu_op     <= ALU_NONE;
			o_instr_type <= T_NONE;
			o_reg_write  <= 1'b0;
			o_mem_access <= MEM_NONE;
			o_mem_size   <= SZ_NONE;
			o_branch     <= BR_NONE;
			o_is_ecall   <= 1'b0;
			o_is_word    <= 1'b0;
			o_illegal    <= 1'b0;
		end else begin
			o_wb_ack <= req;
			// outputs hold until the next accepted request
			if (req) begin
				o_rd         <= dec.rd;
				o_rs1        <= dec.rs1;
				o_rs2        <= dec.rs2;
				o_imm        <= dec.imm;
				o_alu_op     <= dec.alu_op;
				o_instr_type <= dec.instr_type;
				o_reg_write  <= dec.reg_write;
				o_mem_access <= dec.mem_access;
				o_mem_size   <= dec.mem_size;
				o_branch     <= dec.branch;
				o_is_ecall   <= dec.is_ecall;
				o_is_word    <= dec.is_word;
				o_illegal    <= dec.illegal;
			end
		end
	end

endmodule

// File: rv_decoder_top.sv
`timescale 1ns/1ps

module rv_decoder_top
	import rv_decode_pkg::*;
#(
	parameter int XLEN_P = XLEN,
	parameter int ILEN_P = ILEN
) (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic [ILEN_P-1:0]     i_wb_dat,
	input  logic [XLEN_P-1:0]     i_pc,
	output logic                  o_wb_ack,
	output logic [REG_ADDR_W-1:0] o_rd,
	output logic [REG_ADDR_W-1:0] o_rs1,
	output logic [REG_ADDR_W-1:0] o_rs2,
	output logic [XLEN_P-1:0]     o_imm,
	output alu_op_e               o_alu_op,
	output instr_type_e           o_instr_type,
	output logic                  o_reg_write,
	output mem_access_e           o_mem_access,
	output mem_size_e             o_mem_size,
	output branch_e               o_branch,
	output logic                  o_is_ecall,
	output logic                  o_is_word,
	output logic                  o_illegal
);

	imm_sel_e imm_sel;

	decode_if #(.XLEN_P(XLEN_P)) u_dec_if ();

	// decode is combinational on the request lines, the slave samples it
	ctrl_decode #(.ILEN_P(ILEN_P)) u_ctrl_decode (
		.i_instr   (i_wb_dat),
		.o_imm_sel (imm_sel),
		.dec       (u_dec_if.producer)
	);

	imm_gen #(.XLEN_P(XLEN_P), .ILEN_P(ILEN_P)) u_imm_gen (
		.i_instr   (i_wb_dat),
		.i_pc      (i_pc),
		.i_imm_sel (imm_sel),
		.dec       (u_dec_if.imm_producer)
	);

	wb_decode_slave #(.XLEN_P(XLEN_P)) u_wb_slave (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.dec          (u_dec_if.consumer),
		.o_wb_ack     (o_wb_ack),
		.o_rd         (o_rd),
		.o_rs1        (o_rs1),
		.o_rs2        (o_rs2),
		.o_imm        (o_imm),
		.o_alu_op     (o_alu_op),
		.o_instr_type (o_instr_type),
		.o_reg_write  (o_reg_write),
		.o_mem_access (o_mem_access),
		.o_mem_size   (o_mem_size),
		.o_branch     (o_branch),
		.o_is_ecall   (o_is_ecall),
		.o_is_word    (o_is_word),
		.o_illegal    (o_illegal)
	);

endmodule

// File: rv_decoder_props.sv
`timescale 1ns/1ps

module rv_decoder_props (
	input logic clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_ack
);

	property ack_low_after_reset;
		@(posedge clk) i_reset |=> !i_wb_ack;
	endproperty

	// ack is a single-cycle pulse
	property ack_one_cycle;
		@(posedge clk) disable iff (i_reset)
			i_wb_ack |=> !i_wb_ack;
	endproperty

	property ack_after_request;
		@(posedge clk) disable iff (i_reset)
			$rose(i_wb_ack) |-> $past(i_wb_cyc && i_wb_stb && !i_wb_ack);
	endproperty

	a_ack_low_after_reset: assert property (ack_low_after_reset)
		else $error("ack high in the cycle after reset");

	a_ack_one_cycle: assert property (ack_one_cycle)
		else $error("ack high for two cycles in a row");

	a_ack_after_request: assert property (ack_after_request)
		else $error("ack rose without a request in the cycle before");

endmodule

bind wb_decode_slave rv_decoder_props u_props (
	.clk      (clk),
	.i_reset  (i_reset),
	.i_wb_cyc (i_wb_cyc),
	.i_wb_stb (i_wb_stb),
	.i_wb_ack (o_wb_ack)
);

// File: tb_rv_decoder.sv
`timescale 1ns/1ps

module tb_rv_decoder;

	localparam int MAX_VEC     = 128;
	localparam int NCOL        = 15;
	localparam int ACK_TIMEOUT = 10;

	// columns of one stimulus line
	localparam int C_INSTR = 0, C_PC = 1, C_RD = 2, C_RS1 = 3, C_RS2 = 4,
		C_IMM = 5, C_ALU = 6, C_TYPE = 7, C_RW = 8, C_MACC = 9,
		C_MSZ = 10, C_BR = 11, C_ECALL = 12, C_WORD = 13, C_ILL = 14;

	logic        clk;
	logic        i_reset;
	logic        i_wb_cyc;
	logic        i_wb_stb;
	logic [31:0] i_wb_dat;
	logic [63:0] i_pc;
	logic        o_wb_ack;
	logic [4:0]  o_rd;
	logic [4:0]  o_rs1;
	logic [4:0]  o_rs2;
	logic [63:0] o_imm;
	logic [4:0]  o_alu_op;
	logic [2:0]  o_instr_type;
	logic        o_reg_write;
	logic [1:0]  o_mem_access;
	logic [2:0]  o_mem_size;
	logic [1:0]  o_branch;
	logic        o_is_ecall;
	logic        o_is_word;
	logic        o_illegal;

	logic [63:0] vec [0:MAX_VEC-1][0:NCOL-1];
	// fields the outputs must show right now
	logic [63:0] cur [0:NCOL-1];
	int          nvec;
	int          mismatches;
	int          other_errors;
	bit          timed_out;

	rv_decoder_top dut (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_dat     (i_wb_dat),
		.i_pc         (i_pc),
		.o_wb_ack     (o_wb_ack),
		.o_rd         (o_rd),
		.o_rs1        (o_rs1),
		.o_rs2        (o_rs2),
		.o_imm        (o_imm),
		.o_alu_op     (o_alu_op),
		.o_instr_type (o_instr_type),
		.o_reg_write  (o_reg_write),
		.o_mem_access (o_mem_access),
		.o_mem_size   (o_mem_size),
		.o_branch     (o_branch),
		.o_is_ecall   (o_is_ecall),
		.o_is_word    (o_is_word),
		.o_illegal    (o_illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_field(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		assert (act === exp) else begin
			$display("Mismatch at time %0t: %s expected %0h, got %0h", $time, name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_outputs();
		check_field("o_rd", cur[C_RD], 64'(o_rd));
		check_field("o_rs1", cur[C_RS1], 64'(o_rs1));
		check_field("o_rs2", cur[C_RS2], 64'(o_rs2));
		check_field("o_imm", cur[C_IMM], o_imm);
		check_field("o_alu_op", cur[C_ALU], 64'(o_alu_op));
		check_field("o_instr_type", cur[C_TYPE], 64'(o_instr_type));
		check_field("o_reg_write", cur[C_RW], 64'(o_reg_write));
		check_field("o_mem_access", cur[C_MACC], 64'(o_mem_access));
		check_field("o_mem_size", cur[C_MSZ], 64'(o_mem_size));
		check_field("o_branch", cur[C_BR], 64'(o_branch));
		check_field("o_is_ecall", cur[C_ECALL], 64'(o_is_ecall));
		check_field("o_is_word", cur[C_WORD], 64'(o_is_word));
		check_field("o_illegal", cur[C_ILL], 64'(o_illegal));
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		int          c;
		string       line;
		logic [63:0] f [0:NCOL-1];
		fd = $fopen("decode_stimulus.txt", "r");
		assert (fd != 0) else begin
			$display("Cannot open decode_stimulus.txt for reading");
			other_errors++;
		end
		if (fd != 0) begin
			while (nvec < MAX_VEC && $fgets(line, fd) > 0) begin
				// comment lines fail the scan and are skipped
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
					f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
				if (n == NCOL) begin
					for (c = 0; c < NCOL; c++)
						vec[nvec][c] = f[c];
					nvec++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_request(input int idx);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_dat = vec[idx][C_INSTR][31:0];
		i_pc     = vec[idx][C_PC];
	endtask

	task automatic release_bus();
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
	endtask

	// counts falling edges from the request up to the one that sees ack
	task automatic wait_ack(input int exp_lat);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			// outputs hold their last values until the ack
			if (!o_wb_ack)
				check_outputs();
		end while (!o_wb_ack && cycles < ACK_TIMEOUT);
		assert (o_wb_ack) else begin
			$display("Timeout at time %0t: no ack within %0d cycles of the request",
				$time, ACK_TIMEOUT);
			other_errors++;
			timed_out = 1'b1;
		end
		if (o_wb_ack)
			check_field("ack latency", 64'(exp_lat), 64'(cycles));
	endtask

	task automatic check_response(input int idx);
		int c;
		for (c = 0; c < NCOL; c++)
			cur[c] = vec[idx][c];
		check_outputs();
	endtask

	initial begin
		int i;
		i_reset      = 1'b1;
		i_wb_cyc     = 1'b0;
		i_wb_stb     = 1'b0;
		i_wb_dat     = '0;
		i_pc         = '0;
		nvec         = 0;
		mismatches   = 0;
		other_errors = 0;
		timed_out    = 1'b0;
		for (i = 0; i < NCOL; i++)
			cur[i] = '0;
		load_vectors();
		assert (nvec > 0) else begin
			$display("No test vectors found in decode_stimulus.txt");
			other_errors++;
		end

		repeat (2) @(posedge clk);
		@(negedge clk);
		i_reset = 1'b0;
		// all outputs read zero after reset
		check_field("o_wb_ack", 64'd0, 64'(o_wb_ack));
		check_outputs();

		// single requests, stb dropped after each ack
		for (i = 0; i < nvec && !timed_out; i++) begin
			drive_request(i);
			wait_ack(1);
			if (!timed_out) begin
				check_response(i);
				release_bus();
				@(negedge clk);
				check_field("o_wb_ack", 64'd0, 64'(o_wb_ack));
				check_outputs();
			end
		end

		// burst with stb held, a held request gets served every second cycle
		for (i = 0; i < nvec && !timed_out; i++) begin
			drive_request(i);
			wait_ack((i == 0) ? 1 : 2);
			if (!timed_out)
				check_response(i);
		end
		release_bus();

		$display("vectors: %0d, mismatches: %0d, other errors: %0d",
			nvec, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: decode_stimulus.txt
# instr pc rd rs1 rs2 imm alu type reg_write mem_access mem_size branch ecall word illegal
# all hex, enum fields as their index in the package, text after the last column is ignored
003100b3 0 01 02 03 0 01 1 1 0 0 0 0 0 0 add
403100b3 0 01 02 03 0 02 1 1 0 0 0 0 0 0 sub
003110b3 0 01 02 03 0 03 1 1 0 0 0 0 0 0 sll
003130b3 0 01 02 03 0 05 1 1 0 0 0 0 0 0 sltu
403150b3 0 01 02 03 0 08 1 1 0 0 0 0 0 0 sra
003170b3 0 01 02 03 0 0a 1 1 0 0 0 0 0 0 and
023100b3 0 01 02 03 0 0b 1 1 0 0 0 0 0 0 mul
023110b3 0 01 02 03 0 0c 1 1 0 0 0 0 0 0 mulh
023120b3 0 01 02 03 0 0d 1 1 0 0 0 0 0 0 mulhsu
023130b3 0 01 02 03 0 0e 1 1 0 0 0 0 0 0 mulhu
023140b3 0 01 02 03 0 0f 1 1 0 0 0 0 0 0 div
023150b3 0 01 02 03 0 10 1 1 0 0 0 0 0 0 divu
023160b3 0 01 02 03 0 11 1 1 0 0 0 0 0 0 rem
023170b3 0 01 02 03 0 12 1 1 0 0 0 0 0 0 remu
003100bb 0 01 02 03 0 01 1 1 0 0 0 0 1 0 addw
403100bb 0 01 02 03 0 02 1 1 0 0 0 0 1 0 subw
403150bb 0 01 02 03 0 08 1 1 0 0 0 0 1 0 sraw
023100bb 0 01 02 03 0 0b 1 1 0 0 0 0 1 0 mulw
023150bb 0 01 02 03 0 10 1 1 0 0 0 0 1 0 divuw
023160bb 0 01 02 03 0 11 1 1 0 0 0 0 1 0 remw
fff30293 0 05 06 1f ffffffffffffffff 01 2 1 0 0 0 0 0 0 addi -1
7ff33293 0 05 06 1f 7ff 05 2 1 0 0 0 0 0 0 sltiu 2047
80034293 0 05 06 00 fffffffffffff800 06 2 1 0 0 0 0 0 0 xori -2048
03f31293 0 05 06 1f 3f 03 2 1 0 0 0 0 0 0 slli 63
42135293 0 05 06 01 21 08 2 1 0 0 0 0 0 0 srai 33
ff03029b 0 05 06 10 fffffffffffffff0 01 2 1 0 0 0 0 1 0 addiw -16
01f3129b 0 05 06 1f 1f 03 2 1 0 0 0 0 1 0 slliw 31
0073529b 0 05 06 07 7 07 2 1 0 0 0 0 1 0 srliw 7
4143529b 0 05 06 14 14 08 2 1 0 0 0 0 1 0 sraiw 20
800003b7 0 07 00 00 ffffffff80000000 1a 5 1 0 0 0 0 0 0 lui
12345397 80001000 07 08 03 92346000 1a 5 1 0 0 0 0 0 0 auipc
ffc48403 0 08 09 1c fffffffffffffffc 01 2 1 1 1 0 0 0 0 lb -4
00249403 0 08 09 02 2 01 2 1 1 2 0 0 0 0 lh
0084a403 0 08 09 08 8 01 2 1 1 3 0 0 0 0 lw
0104b403 0 08 09 10 10 01 2 1 1 4 0 0 0 0 ld
0014c403 0 08 09 01 1 01 2 1 1 5 0 0 0 0 lbu
ffe4d403 0 08 09 1e fffffffffffffffe 01 2 1 1 6 0 0 0 0 lhu -2
7fc4e403 0 08 09 1c 7fc 01 2 1 1 7 0 0 0 0 lwu
fea48ea3 0 1d 09 0a fffffffffffffffd 01 3 0 2 1 0 0 0 0 sb -3
00a49323 0 06 09 0a 6 01 3 0 2 2 0 0 0 0 sh
00a4a623 0 0c 09 0a c 01 3 0 2 3 0 0 0 0 sw
02a4b423 0 08 09 0a 28 01 3 0 2 4 0 0 0 0 sd
00c58863 2000 10 0b 0c 2010 13 4 0 0 0 1 0 0 0 beq +16
fec59ce3 100000004 19 0b 0c fffffffc 14 4 0 0 0 1 0 0 0 bne -8
00c5c0e3 2000 01 0b 0c 2800 15 4 0 0 0 1 0 0 0 blt +2048
00c5d263 2000 04 0b 0c 2004 16 4 0 0 0 1 0 0 0 bge +4
80c5e063 2000 00 0b 0c 1000 17 4 0 0 0 1 0 0 0 bltu -4096
7ec5ffe3 2000 1f 0b 0c 2ffe 18 4 0 0 0 1 0 0 0 bgeu +4094
f01ff0ef 4000 01 1f 01 3f00 19 6 1 0 0 2 0 0 0 jal -256
ff4280e7 4000 01 05 14 fffffffffffffff4 01 2 1 0 0 2 0 0 0 jalr -12
00000073 5000 00 00 00 0 00 0 0 0 0 0 1 0 0 ecall
00100073 5000 00 00 01 0 00 0 0 0 0 0 0 0 1 ebreak
003100ff 0 01 02 03 0 00 0 0 0 0 0 0 0 1 unknown opcode
003120bb 0 01 02 03 0 00 0 0 0 0 0 0 0 1 sltw

// File: flist.f
rv_decode_pkg.sv
decode_if.sv
ctrl_decode.sv
imm_gen.sv
wb_decode_slave.sv
rv_decoder_top.sv
rv_decoder_props.sv
tb_rv_decoder.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_rv_decoder -f flist.f
	./obj_dir/Vtb_rv_decoder | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
